// File: logic/rename_consts.svh
`ifndef RENAME_CONSTS_SVH
`define RENAME_CONSTS_SVH

// architectural register file size
`define NUM_ARCH 32

// physical register file size
`define NUM_PR 64

// ROB depth, also the number of map checkpoints
`define NUM_ROB 16

// arch register that always reads as ready
`define ZERO_REG 31

// free tags after reset, one credit per tag
`define RENAME_INIT_CREDITS (`NUM_PR - `NUM_ARCH)

`endif

// File: logic/rename_pkg.sv
`default_nettype none

`include "rename_consts.svh"

package rename_pkg;

  // physical register tag
  typedef logic [$clog2(`NUM_PR)-1:0] phys_tag_t;

  // architectural register index
  typedef logic [$clog2(`NUM_ARCH)-1:0] arch_idx_t;

  // ROB entry index, also selects a checkpoint
  typedef logic [$clog2(`NUM_ROB)-1:0] rob_idx_t;

  // credit count, must reach the full initial credit value
  typedef logic [$clog2(`RENAME_INIT_CREDITS + 1)-1:0] credit_count_t;

endpackage

`default_nettype wire

// File: logic/map_table.sv
`timescale 1ns/1ps
`default_nettype none

`include "rename_consts.svh"

module map_table
  import rename_pkg::*;
(
  input  wire             clock,
  input  wire             reset,
  // dispatch from the decoder
  input  wire             dispatch_en,
  input  wire arch_idx_t  dest_idx,
  input  wire arch_idx_t  src_a_idx,
  input  wire arch_idx_t  src_b_idx,
  input  wire rob_idx_t   rob_idx,
  // head of the free list
  input  wire phys_tag_t  new_tag,
  // result bus
  input  wire             complete_en,
  input  wire phys_tag_t  complete_tag,
  input  wire arch_idx_t  complete_dest_idx,
  // ROB rollback
  input  wire             rollback_en,
  input  wire rob_idx_t   rollback_idx,
  // lookups, all combinational
  output phys_tag_t       told_tag,
  output phys_tag_t       src_a_tag,
  output logic            src_a_ready,
  output phys_tag_t       src_b_tag,
  output logic            src_b_ready
);

  // current map, tag and ready bit per arch register
  phys_tag_t             map_tag [`NUM_ARCH];
  logic [`NUM_ARCH-1:0]  map_ready;

  // next-state map
  phys_tag_t             next_tag [`NUM_ARCH];
  logic [`NUM_ARCH-1:0]  next_ready;

  // one snapshot per ROB entry
  // ready bits are all set in every snapshot, so only tags are kept
  phys_tag_t             ckpt_tag [`NUM_ROB][`NUM_ARCH];

  // bypass hits from the result bus
  logic                  bypass_a;
  logic                  bypass_b;

  // stale completions must not mark a renamed register ready
  logic                  complete_match;

  // T_old for the ROB
  assign told_tag  = map_tag[dest_idx];

  // source tags straight from the current map
  assign src_a_tag = map_tag[src_a_idx];
  assign src_b_tag = map_tag[src_b_idx];

  // same-cycle completion counts as ready
  assign bypass_a    = complete_en && (src_a_tag == complete_tag);
  assign bypass_b    = complete_en && (src_b_tag == complete_tag);
  assign src_a_ready = map_ready[src_a_idx] || bypass_a;
  assign src_b_ready = map_ready[src_b_idx] || bypass_b;

  assign complete_match = complete_en && (map_tag[complete_dest_idx] == complete_tag);

  // order: rollback, completion, dispatch
  always_comb begin
    next_tag   = map_tag;
    next_ready = map_ready;

    // restore snapshot, every register ready
    if (rollback_en) begin
      next_tag   = ckpt_tag[rollback_idx];
      next_ready = '1;
    end

    // completion compares against the map before this cycle
    if (complete_match) begin
      next_ready[complete_dest_idx] = 1'b1;
    end

    // new mapping is pending until its result arrives
    if (dispatch_en) begin
      next_tag[dest_idx]     = new_tag;
      next_ready[dest_idx]   = 1'b0;
      // zero reg never waits
      next_ready[`ZERO_REG]  = 1'b1;
    end
  end

  // map state
  always_ff @(posedge clock) begin
    if (reset) begin
      // identity map, all ready
      for (int i = 0; i < `NUM_ARCH; i++) begin
        map_tag[i] <= phys_tag_t'(i);
      end
      map_ready <= '1;
    end else begin
      map_tag   <= next_tag;
      map_ready <= next_ready;
    end
  end

  // snapshot storage
  // taken after this dispatch's own write, so rollback keeps its mapping
  always_ff @(posedge clock) begin
    if (dispatch_en) begin
      ckpt_tag[rob_idx] <= next_tag;
    end
  end

endmodule

`default_nettype wire

// File: logic/free_list.sv
`timescale 1ns/1ps
`default_nettype none

`include "rename_consts.svh"

module free_list
  import rename_pkg::*;
(
  input  wire            clock,
  input  wire            reset,
  // pop on dispatch
  input  wire            dispatch_en,
  input  wire rob_idx_t  rob_idx,
  // push T_old on retirement
  input  wire            retire_en,
  input  wire phys_tag_t retire_tag,
  // ROB rollback
  input  wire            rollback_en,
  input  wire rob_idx_t  rollback_idx,
  // head of the ring
  output phys_tag_t      new_tag,
  // credits back to the decoder
  output logic           credit_return,
  output logic           credit_restore_valid,
  output credit_count_t  credit_restore_count
);

  // ring index width, pointers carry one extra wrap bit
  localparam int PTR_W = $clog2(`NUM_PR);

  typedef logic [PTR_W:0] ptr_t;

  // free tags
  phys_tag_t  ring [`NUM_PR];

  // head pops, tail pushes
  ptr_t       head;
  ptr_t       tail;
  ptr_t       head_popped;

  // head after each dispatch's pop, per ROB entry
  ptr_t       head_ckpt [`NUM_ROB];

  // tag handed out this cycle
  assign new_tag = ring[head[PTR_W-1:0]];

  // head once the current pop is done
  assign head_popped = head + ptr_t'(1);

  // pointers
  always_ff @(posedge clock) begin
    if (reset) begin
      // ring starts holding the non-arch tags
      head <= '0;
      tail <= ptr_t'(`RENAME_INIT_CREDITS);
    end else begin
      if (rollback_en) begin
        head <= head_ckpt[rollback_idx];
      end else if (dispatch_en) begin
        head <= head_popped;
      end
      if (retire_en) begin
        tail <= tail + ptr_t'(1);
      end
    end
  end

  // ring contents
  // entry i holds tag NUM_ARCH+i after reset, upper half wraps and is unused
  always_ff @(posedge clock) begin
    if (reset) begin
      for (int i = 0; i < `NUM_PR; i++) begin
        ring[i] <= phys_tag_t'(i + `NUM_ARCH);
      end
    end else if (retire_en) begin
      ring[tail[PTR_W-1:0]] <= retire_tag;
    end
  end

  // head checkpoints and the rollback distance
  always_ff @(posedge clock) begin
    if (dispatch_en) begin
      head_ckpt[rob_idx] <= head_popped;
    end
    // tags popped after the restored point go back as credits
    if (rollback_en) begin
      credit_restore_count <= credit_count_t'(head - head_ckpt[rollback_idx]);
    end
  end

  // one-cycle credit strobes
  always_ff @(posedge clock) begin
    if (reset) begin
      credit_return        <= 1'b0;
      credit_restore_valid <= 1'b0;
    end else begin
      credit_return        <= retire_en;
      credit_restore_valid <= rollback_en;
    end
  end

endmodule

`default_nettype wire

// File: logic/rename_unit.sv
`timescale 1ns/1ps
`default_nettype none

`include "rename_consts.svh"

module rename_unit
  import rename_pkg::*;
(
  input  wire            clock,
  input  wire            reset,
  // dispatch from the decoder
  input  wire            dispatch_en,
  input  wire arch_idx_t dest_idx,
  input  wire arch_idx_t src_a_idx,
  input  wire arch_idx_t src_b_idx,
  input  wire rob_idx_t  rob_idx,
  // same-cycle rename results
  output phys_tag_t      new_tag,
  output phys_tag_t      told_tag,
  output phys_tag_t      src_a_tag,
  output logic           src_a_ready,
  output phys_tag_t      src_b_tag,
  output logic           src_b_ready,
  // result bus
  input  wire            complete_en,
  input  wire phys_tag_t complete_tag,
  input  wire arch_idx_t complete_dest_idx,
  // retirement from the ROB
  input  wire            retire_en,
  input  wire phys_tag_t retire_tag,
  // rollback from the ROB
  input  wire            rollback_en,
  input  wire rob_idx_t  rollback_idx,
  // credits to the decoder
  output logic           credit_return,
  output logic           credit_restore_valid,
  output credit_count_t  credit_restore_count
);

  // arch to phys mapping with checkpoints
  map_table u_map_table (
    .clock             (clock),
    .reset             (reset),
    .dispatch_en       (dispatch_en),
    .dest_idx          (dest_idx),
    .src_a_idx         (src_a_idx),
    .src_b_idx         (src_b_idx),
    .rob_idx           (rob_idx),
    // free list head feeds the dest write
    .new_tag           (new_tag),
    .complete_en       (complete_en),
    .complete_tag      (complete_tag),
    .complete_dest_idx (complete_dest_idx),
    .rollback_en       (rollback_en),
    .rollback_idx      (rollback_idx),
    .told_tag          (told_tag),
    .src_a_tag         (src_a_tag),
    .src_a_ready       (src_a_ready),
    .src_b_tag         (src_b_tag),
    .src_b_ready       (src_b_ready)
  );

  // ring of unused tags and the credit strobes
  free_list u_free_list (
    .clock                (clock),
    .reset                (reset),
    .dispatch_en          (dispatch_en),
    .rob_idx              (rob_idx),
    .retire_en            (retire_en),
    .retire_tag           (retire_tag),
    .rollback_en          (rollback_en),
    .rollback_idx         (rollback_idx),
    .new_tag              (new_tag),
    .credit_return        (credit_return),
    .credit_restore_valid (credit_restore_valid),
    .credit_restore_count (credit_restore_count)
  );

endmodule

`default_nettype wire

// File: verification/rename_unit_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "rename_consts.svh"

module rename_unit_tb
  import rename_pkg::*;
();

  // run limit in cycles
  localparam int MAX_CYCLES = 2000;

  logic          clock = 1'b0;
  logic          reset;
  logic          dispatch_en;
  arch_idx_t     dest_idx;
  arch_idx_t     src_a_idx;
  arch_idx_t     src_b_idx;
  rob_idx_t      rob_idx;
  phys_tag_t     new_tag;
  phys_tag_t     told_tag;
  phys_tag_t     src_a_tag;
  logic          src_a_ready;
  phys_tag_t     src_b_tag;
  logic          src_b_ready;
  logic          complete_en;
  phys_tag_t     complete_tag;
  arch_idx_t     complete_dest_idx;
  logic          retire_en;
  phys_tag_t     retire_tag;
  logic          rollback_en;
  rob_idx_t      rollback_idx;
  logic          credit_return;
  logic          credit_restore_valid;
  credit_count_t credit_restore_count;

  // software model of map, snapshots and free ring
  phys_tag_t            m_tag [`NUM_ARCH];
  logic [`NUM_ARCH-1:0] m_ready;
  phys_tag_t            snap_tag [`NUM_ROB][`NUM_ARCH];
  int                   snap_head [`NUM_ROB];
  phys_tag_t            m_ring [`NUM_PR];
  int                   m_head;
  int                   m_tail;
  // tag popped by each dispatch, and its T_old
  phys_tag_t            pop_hist [$];
  phys_tag_t            told_hist [$];

  integer seed;
  int     errors = 0;
  int     checks = 0;
  int     credits;
  int     disp_count = 0;
  int     pulses = 0;
  int     expect_restore = 0;
  int     cycle_count = 0;
  logic   last_retire = 1'b0;
  logic   last_rollback = 1'b0;

  rename_unit dut (.*);

  always #5 clock = ~clock;

  // hang guard
  always @(posedge clock) begin
    cycle_count++;
    if (cycle_count >= MAX_CYCLES) begin
      $display("timeout: run did not finish within %0d cycles", MAX_CYCLES);
      $display("** FAIL **");
      $finish;
    end
  end

  task automatic compare_value(input string what, input int got, input int exp);
    checks++;
    assert (got == exp) else begin
      $display("ERR %0t: %s is %0d, expected %0d", $time, what, got, exp);
      errors++;
    end
  endtask

  function automatic arch_idx_t pick_reg();
    return arch_idx_t'($unsigned($random(seed)) % `NUM_ARCH);
  endfunction

  task automatic idle_inputs();
    dispatch_en = 1'b0;
    dest_idx = '0;
    src_a_idx = '0;
    src_b_idx = '0;
    rob_idx = '0;
    complete_en = 1'b0;
    complete_tag = '0;
    complete_dest_idx = '0;
    retire_en = 1'b0;
    retire_tag = '0;
    rollback_en = 1'b0;
    rollback_idx = '0;
  endtask

  // strobes are one cycle behind retire_en and rollback_en
  task automatic check_strobes();
    compare_value("credit_return", credit_return, last_retire);
    compare_value("credit_restore_valid", credit_restore_valid, last_rollback);
    if (credit_restore_valid) begin
      compare_value("credit_restore_count", credit_restore_count, expect_restore);
      credits += credit_restore_count;
    end
    if (credit_return) begin
      pulses++;
      credits++;
    end
    last_retire = retire_en;
    last_rollback = rollback_en;
  endtask

  // lookup with same-cycle bypass
  task automatic check_sources();
    logic exp_a;
    logic exp_b;
    exp_a = m_ready[src_a_idx] || (complete_en && m_tag[src_a_idx] == complete_tag);
    exp_b = m_ready[src_b_idx] || (complete_en && m_tag[src_b_idx] == complete_tag);
    compare_value("src_a_tag", src_a_tag, m_tag[src_a_idx]);
    compare_value("src_a_ready", src_a_ready, exp_a);
    compare_value("src_b_tag", src_b_tag, m_tag[src_b_idx]);
    compare_value("src_b_ready", src_b_ready, exp_b);
  endtask

  task automatic idle_step();
    @(negedge clock);
    idle_inputs();
    #2;
    check_strobes();
  endtask

  task automatic lookup_step(input arch_idx_t a, input arch_idx_t b);
    @(negedge clock);
    idle_inputs();
    src_a_idx = a;
    src_b_idx = b;
    #2;
    check_strobes();
    check_sources();
  endtask

  task automatic check_all_lookups();
    for (int i = 0; i < `NUM_ARCH; i++) begin
      lookup_step(arch_idx_t'(i), arch_idx_t'(`ZERO_REG));
      compare_value("zero reg ready", src_b_ready, 1);
    end
  endtask

  task automatic dispatch_one(input arch_idx_t d, input arch_idx_t a, input arch_idx_t b);
    phys_tag_t exp_new;
    rob_idx_t  r;
    exp_new = m_ring[m_head % `NUM_PR];
    r = rob_idx_t'(disp_count % `NUM_ROB);
    if (credits <= 0) begin
      $display("protocol error: dispatch attempted without a credit");
      errors++;
    end
    @(negedge clock);
    idle_inputs();
    dispatch_en = 1'b1;
    dest_idx = d;
    src_a_idx = a;
    src_b_idx = b;
    rob_idx = r;
    #2;
    check_strobes();
    check_sources();
    compare_value("new_tag", new_tag, exp_new);
    compare_value("told_tag", told_tag, m_tag[d]);
    // model write, then snapshot with all ready
    pop_hist.push_back(exp_new);
    told_hist.push_back(m_tag[d]);
    m_tag[d] = exp_new;
    m_ready[d] = (d == `ZERO_REG);
    m_head++;
    credits--;
    disp_count++;
    snap_tag[r] = m_tag;
    snap_head[r] = m_head;
  endtask

  task automatic complete_step(input phys_tag_t t, input arch_idx_t d, input arch_idx_t a);
    @(negedge clock);
    idle_inputs();
    complete_en = 1'b1;
    complete_tag = t;
    complete_dest_idx = d;
    src_a_idx = a;
    src_b_idx = a;
    #2;
    check_strobes();
    check_sources();
    if (m_tag[d] == t) begin
      m_ready[d] = 1'b1;
    end
  endtask

  task automatic retire_step(input phys_tag_t t);
    @(negedge clock);
    idle_inputs();
    retire_en = 1'b1;
    retire_tag = t;
    #2;
    check_strobes();
    m_ring[m_tail % `NUM_PR] = t;
    m_tail++;
  endtask

  task automatic rollback_step(input int target);
    rob_idx_t r;
    r = rob_idx_t'(target % `NUM_ROB);
    @(negedge clock);
    idle_inputs();
    rollback_en = 1'b1;
    rollback_idx = r;
    #2;
    check_strobes();
    m_tag = snap_tag[r];
    m_ready = '1;
    m_head = snap_head[r];
    expect_restore = disp_count - 1 - target;
  endtask

  task automatic report_test(input string name, input int err_start);
    $display("test %s finished with %0d errors", name, errors - err_start);
  endtask

  task automatic reset_state_test();
    int e0;
    e0 = errors;
    for (int i = 0; i < `NUM_ARCH; i++) begin
      lookup_step(arch_idx_t'(i), arch_idx_t'(`NUM_ARCH - 1 - i));
      compare_value("reset tag", src_a_tag, i);
    end
    report_test("reset_state", e0);
  endtask

  task automatic renaming_test();
    int e0;
    e0 = errors;
    for (int k = 0; k < 12; k++) begin
      dispatch_one(pick_reg(), pick_reg(), pick_reg());
      // first pops come out of the reset ring in order
      compare_value("ascending new_tag", new_tag, `NUM_ARCH + k);
    end
    // zero reg as destination still reads ready
    dispatch_one(arch_idx_t'(`ZERO_REG), pick_reg(), pick_reg());
    check_all_lookups();
    report_test("renaming", e0);
  endtask

  task automatic completion_test();
    int        e0;
    phys_tag_t stale;
    e0 = errors;
    dispatch_one(arch_idx_t'(5), arch_idx_t'(5), arch_idx_t'(6));
    // matching completion, bypassed into the lookup
    complete_step(m_tag[5], arch_idx_t'(5), arch_idx_t'(5));
    compare_value("bypass ready", src_a_ready, 1);
    lookup_step(arch_idx_t'(5), arch_idx_t'(5));
    compare_value("completed ready", src_a_ready, 1);
    // r6 renamed twice, first tag is stale
    dispatch_one(arch_idx_t'(6), arch_idx_t'(6), arch_idx_t'(6));
    stale = m_tag[6];
    dispatch_one(arch_idx_t'(6), arch_idx_t'(6), arch_idx_t'(6));
    complete_step(stale, arch_idx_t'(6), arch_idx_t'(6));
    compare_value("stale bypass ready", src_a_ready, 0);
    lookup_step(arch_idx_t'(6), arch_idx_t'(6));
    compare_value("stale ready", src_a_ready, 0);
    report_test("completion", e0);
  endtask

  task automatic retirement_test();
    int e0;
    e0 = errors;
    pulses = 0;
    for (int k = 0; k < 6; k++) begin
      retire_step(told_hist[k]);
    end
    idle_step();
    idle_step();
    compare_value("credit pulses", pulses, 6);
    // drain the free list using the credits
    while (credits > 0) begin
      dispatch_one(pick_reg(), pick_reg(), pick_reg());
      // last six pops hand back the retired tags in order
      if (credits < 6) begin
        compare_value("recycled tag", new_tag, told_hist[5 - credits]);
      end
    end
    report_test("retirement", e0);
  endtask

  task automatic rollback_test();
    int        e0;
    int        target;
    phys_tag_t exp_next;
    e0 = errors;
    target = disp_count - 6;
    exp_next = pop_hist[target + 1];
    rollback_step(target);
    // count shows up here
    idle_step();
    compare_value("restore count", credit_restore_count, 5);
    check_all_lookups();
    dispatch_one(arch_idx_t'(1), arch_idx_t'(2), arch_idx_t'(3));
    compare_value("tag after rollback", new_tag, exp_next);
    idle_step();
    report_test("rollback", e0);
  endtask

  initial begin
    seed = 32'he49479fb;
    credits = `RENAME_INIT_CREDITS;
    for (int i = 0; i < `NUM_ARCH; i++) begin
      m_tag[i] = phys_tag_t'(i);
    end
    m_ready = '1;
    // free ring after reset
    for (int i = 0; i < `NUM_PR; i++) begin
      m_ring[i] = phys_tag_t'(i + `NUM_ARCH);
    end
    m_head = 0;
    m_tail = `RENAME_INIT_CREDITS;
    idle_inputs();
    reset = 1'b1;
    repeat (5) @(posedge clock);
    @(negedge clock);
    reset = 1'b0;
    reset_state_test();
    renaming_test();
    completion_test();
    retirement_test();
    rollback_test();
    @(negedge clock);
    $display("checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: rename.f
+incdir+logic
logic/rename_pkg.sv
logic/map_table.sv
logic/free_list.sv
logic/rename_unit.sv
verification/rename_unit_tb.sv

// File: Bender.yml
package:
  name: rename

export_include_dirs:
  - logic

sources:
  - include_dirs:
      - logic
    files:
      - logic/rename_pkg.sv
      - logic/map_table.sv
      - logic/free_list.sv
      - logic/rename_unit.sv
  - target: test
    include_dirs:
      - logic
    files:
      - verification/rename_unit_tb.sv
